/* src/serial_rx_pkg.sv */
// serial receiver shared definitions
package serial_rx_pkg;

    // bits per serial word, MSB first on the link
    localparam int word_width = 8;

    // header length field, bits 5..0 of the header word
    localparam int len_width = 6;

    // bit counter, room for words of up to 16 bits
    localparam int count_width = 4;

    // payload buffer
    localparam int fifo_depth      = 16;
    localparam int fifo_addr_width = 4;

    // header opcode, bits 7..6 of the header word
    typedef enum logic [1:0] {
        // header only, no payload, no trailer, no status
        op_idle  = 2'd0,
        // payload forwarded, status reported
        op_data  = 2'd1,
        // rejected with an error status
        op_rsvd2 = 2'd2,
        op_rsvd3 = 2'd3
    } opcode_t;

    // position inside a frame
    typedef enum logic [1:0] {
        st_header  = 2'd0,
        st_payload = 2'd1,
        st_trailer = 2'd2
    } parser_state_t;

endpackage

/* src/bit_deserializer.sv */
// serial to word deserializer
module bit_deserializer (
    input  logic                                 bit_clk,
    input  logic                                 reset,
    input  logic                                 serial_in,
    input  logic                                 frame_sync,
    output logic [serial_rx_pkg::word_width-1:0] word,
    output logic                                 word_valid,
    output logic                                 frame_start
);
    import serial_rx_pkg::*;

    logic                   serial_q;
    logic                   sync_q;
    logic                   aligned;
    logic [count_width-1:0] bit_count;
    logic                   word_complete;
    logic                   complete_d1;
    logic                   complete_d2;
    logic                   sync_d1;
    logic                   sync_d2;
    logic [word_width-1:0]  shift_d1;
    logic [word_width-1:0]  shift_d2;

    // input capture
    always_ff @(posedge bit_clk) begin
        serial_q <= serial_in;
    end

    always_ff @(posedge bit_clk or posedge reset) begin
        if (reset) begin
            sync_q <= 1'b0;
        end else begin
            sync_q <= frame_sync;
        end
    end

    // bit index of the captured bit, restarted by each sync
    always_ff @(posedge bit_clk or posedge reset) begin
        if (reset) begin
            bit_count <= '0;
            aligned   <= 1'b0;
        end else if (sync_q) begin
            bit_count <= '0;
            aligned   <= 1'b1;
        end else if (bit_count == count_width'(word_width - 1)) begin
            bit_count <= '0;
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // no words before the first frame_sync
    assign word_complete = aligned && (bit_count == count_width'(word_width - 1));

    // shift pipeline, next word may assemble while this one drains
    always_ff @(posedge bit_clk) begin
        shift_d1 <= {shift_d1[word_width-2:0], serial_q};
        shift_d2 <= shift_d1;
        if (complete_d2) begin
            word <= shift_d2;
        end
    end

    // frame_start travels in step with the word pipeline
    always_ff @(posedge bit_clk or posedge reset) begin
        if (reset) begin
            complete_d1 <= 1'b0;
            complete_d2 <= 1'b0;
            sync_d1     <= 1'b0;
            sync_d2     <= 1'b0;
            word_valid  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            complete_d1 <= word_complete;
            complete_d2 <= complete_d1;
            sync_d1     <= sync_q;
            sync_d2     <= sync_d1;
            // sync slot holds no data bit
            word_valid  <= complete_d2 && !sync_d2;
            frame_start <= sync_d2;
        end
    end

endmodule

/* src/frame_parser.sv */
// frame parser and status
module frame_parser (
    input  logic                                 bit_clk,
    input  logic                                 reset,
    input  logic [serial_rx_pkg::word_width-1:0] word,
    input  logic                                 word_valid,
    input  logic                                 frame_start,
    input  logic                                 fifo_full,
    output logic                                 push,
    output logic [serial_rx_pkg::word_width-1:0] push_data,
    output logic                                 push_last,
    output logic                                 frame_done,
    output logic                                 frame_error
);
    import serial_rx_pkg::*;

    parser_state_t         state;
    opcode_t               hdr_op;
    logic [len_width-1:0]  hdr_len;
    logic [len_width-1:0]  remaining;
    logic [word_width-1:0] checksum;
    logic                  frame_err;
    logic                  hold;

    // header fields
    assign hdr_op  = opcode_t'(word[word_width-1 -: 2]);
    assign hdr_len = word[len_width-1:0];

    always_ff @(posedge bit_clk or posedge reset) begin
        if (reset) begin
            state       <= st_header;
            hold        <= 1'b0;
            remaining   <= '0;
            frame_err   <= 1'b0;
            push        <= 1'b0;
            frame_done  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            push        <= 1'b0;
            frame_done  <= 1'b0;
            frame_error <= 1'b0;
            if (frame_start) begin
                // unfinished data frame counts as aborted
                if (state != st_header) begin
                    frame_done  <= 1'b1;
                    frame_error <= 1'b1;
                end
                state <= st_header;
                hold  <= 1'b0;
            end else if (word_valid && !hold) begin
                case (state)
                    st_header: begin
                        if (hdr_op == op_data && hdr_len != '0) begin
                            remaining <= hdr_len;
                            frame_err <= 1'b0;
                            state     <= st_payload;
                        end else if (hdr_op != op_idle) begin
                            // reserved opcode or empty data frame,
                            // ignore the rest until the next sync
                            frame_done  <= 1'b1;
                            frame_error <= 1'b1;
                            hold        <= 1'b1;
                        end
                    end
                    st_payload: begin
                        if (fifo_full) begin
                            frame_err <= 1'b1;
                        end else begin
                            push <= 1'b1;
                        end
                        remaining <= remaining - 1'b1;
                        if (remaining == len_width'(1)) begin
                            state <= st_trailer;
                        end
                    end
                    st_trailer: begin
                        frame_done  <= 1'b1;
                        frame_error <= frame_err || (word != checksum);
                        state       <= st_header;
                    end
                    default: begin
                        state <= st_header;
                    end
                endcase
            end
        end
    end

    // running xor over the payload
    always_ff @(posedge bit_clk) begin
        if (word_valid) begin
            if (state == st_header) begin
                checksum <= '0;
            end else if (state == st_payload) begin
                checksum <= checksum ^ word;
            end
            push_data <= word;
            push_last <= (remaining == len_width'(1));
        end
    end

endmodule

/* src/word_fifo.sv */
// payload word fifo
module word_fifo (
    input  logic                                 bit_clk,
    input  logic                                 reset,
    input  logic                                 push,
    input  logic [serial_rx_pkg::word_width-1:0] push_data,
    input  logic                                 push_last,
    input  logic                                 rx_ready,
    output logic                                 fifo_full,
    output logic [serial_rx_pkg::word_width-1:0] rx_data,
    output logic                                 rx_last,
    output logic                                 rx_valid
);
    import serial_rx_pkg::*;

    logic [word_width-1:0]      data_mem [fifo_depth];
    logic                       last_mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_ptr;
    logic [fifo_addr_width-1:0] rd_ptr;
    logic [fifo_addr_width:0]   count;
    logic                       do_push;
    logic                       do_pop;

    function automatic logic [fifo_addr_width-1:0] next_ptr(
        input logic [fifo_addr_width-1:0] ptr
    );
        return (ptr == fifo_addr_width'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fifo_full = (count == (fifo_addr_width + 1)'(fifo_depth));
    assign rx_valid  = (count != '0);
    assign do_push   = push && !fifo_full;
    assign do_pop    = rx_valid && rx_ready;
    assign rx_data   = data_mem[rd_ptr];
    assign rx_last   = last_mem[rd_ptr];

    always_ff @(posedge bit_clk) begin
        if (do_push) begin
            data_mem[wr_ptr] <= push_data;
            last_mem[wr_ptr] <= push_last;
        end
    end

    always_ff @(posedge bit_clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* src/serial_rx_top.sv */
// framed serial receiver
module serial_rx_top (
    input  logic                                 bit_clk,
    input  logic                                 reset,
    input  logic                                 serial_in,
    input  logic                                 frame_sync,
    input  logic                                 rx_ready,
    output logic [serial_rx_pkg::word_width-1:0] rx_data,
    output logic                                 rx_last,
    output logic                                 rx_valid,
    output logic                                 frame_done,
    output logic                                 frame_error
);
    import serial_rx_pkg::*;

    logic [word_width-1:0] word;
    logic                  word_valid;
    logic                  frame_start;
    logic                  push;
    logic [word_width-1:0] push_data;
    logic                  push_last;
    logic                  fifo_full;

    bit_deserializer deser0 (
        .bit_clk     (bit_clk),
        .reset       (reset),
        .serial_in   (serial_in),
        .frame_sync  (frame_sync),
        .word        (word),
        .word_valid  (word_valid),
        .frame_start (frame_start)
    );

    frame_parser parser0 (
        .bit_clk     (bit_clk),
        .reset       (reset),
        .word        (word),
        .word_valid  (word_valid),
        .frame_start (frame_start),
        .fifo_full   (fifo_full),
        .push        (push),
        .push_data   (push_data),
        .push_last   (push_last),
        .frame_done  (frame_done),
        .frame_error (frame_error)
    );

    // back-pressure stops here, the link cannot stall
    word_fifo fifo0 (
        .bit_clk   (bit_clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .push_last (push_last),
        .rx_ready  (rx_ready),
        .fifo_full (fifo_full),
        .rx_data   (rx_data),
        .rx_last   (rx_last),
        .rx_valid  (rx_valid)
    );

endmodule

/* verif/clock_gen.sv */
// testbench clock and reset
module clock_gen (
    output logic bit_clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 50;

    initial begin
        bit_clk = 1'b0;
        forever #half_period bit_clk = ~bit_clk;
    end

    // four rising edges in reset, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge bit_clk);
        @(negedge bit_clk);
        reset = 1'b0;
    end

endmodule

/* verif/serial_rx_tb.sv */
// serial receiver testbench
module serial_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import serial_rx_pkg::*;

    // idle bits allowed for the model queues to drain
    localparam int     drain_limit = 400;
    // watchdog budget from the worst case frame and drain lengths
    localparam int     frame_bits  = 1 + word_width * 22;
    localparam longint budget_bits = 39 * frame_bits + 20 * drain_limit + 100;
    localparam longint watchdog_ns = budget_bits * 100 * 2 + 10000;

    logic                  bit_clk;
    logic                  reset;
    logic                  serial_in;
    logic                  frame_sync;
    logic                  rx_ready;
    logic [word_width-1:0] rx_data;
    logic                  rx_last;
    logic                  rx_valid;
    logic                  frame_done;
    logic                  frame_error;

    // model queues
    logic [word_width-1:0] exp_data[$];
    logic                  exp_last[$];
    logic                  exp_err[$];
    string                 test_name;
    // 0 ready high, 1 random, 2 ready low
    int                    ready_mode;
    logic                  held;
    logic [word_width-1:0] held_data;
    logic                  held_last;

    clock_gen clk0 (.bit_clk(bit_clk), .reset(reset));

    serial_rx_top dut0 (
        .bit_clk     (bit_clk),
        .reset       (reset),
        .serial_in   (serial_in),
        .frame_sync  (frame_sync),
        .rx_ready    (rx_ready),
        .rx_data     (rx_data),
        .rx_last     (rx_last),
        .rx_valid    (rx_valid),
        .frame_done  (frame_done),
        .frame_error (frame_error)
    );

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string test, input logic [word_width-1:0] exp_w,
                              input logic exp_l, input logic [word_width-1:0] act_w,
                              input logic act_l);
        if (act_w !== exp_w || act_l !== exp_l) begin
            report_failure($sformatf("MISMATCH %s: expected data %h last %b, actual data %h last %b",
                                     test, exp_w, exp_l, act_w, act_l));
        end
    endtask

    task automatic check_status(input string test, input logic exp_e, input logic act_e);
        if (act_e !== exp_e) begin
            report_failure($sformatf("MISMATCH %s: expected frame_error %b, actual frame_error %b",
                                     test, exp_e, act_e));
        end
    endtask

    function automatic logic pick_ready();
        if (ready_mode == 1) begin
            return ($urandom_range(0, 1) == 1);
        end
        return (ready_mode == 0);
    endfunction

    task automatic drive_bit(input logic b, input logic s);
        @(negedge bit_clk);
        serial_in  <= b;
        frame_sync <= s;
        rx_ready   <= pick_ready();
    endtask

    task automatic serialize_word(input logic [word_width-1:0] w);
        for (int i = word_width - 1; i >= 0; i--) begin
            drive_bit(w[i], 1'b0);
        end
    endtask

    // room is the number of payload words the fifo can still take
    task automatic build_frame(input opcode_t op, input int len, input logic bad_trailer,
                               input int abort_after, input int room);
        parser_state_t         pos;
        logic [word_width-1:0] w;
        logic [word_width-1:0] sum;
        logic                  dropped;
        int                    idx;
        int                    kept;
        drive_bit(1'b0, 1'b1);
        serialize_word({op, len_width'(len)});
        if (!(op == op_data && len != 0)) begin
            if (op != op_idle) begin
                exp_err.push_back(1'b1);
                // ignored by the parser until the next sync
                repeat (len + 1) serialize_word(word_width'($urandom));
            end
            return;
        end
        sum = '0;
        dropped = 1'b0;
        idx = 0;
        kept = 0;
        pos = st_payload;
        while (pos != st_header) begin
            case (pos)
                st_payload: begin
                    if (idx == abort_after) begin
                        repeat (3) drive_bit($urandom_range(0, 1) == 1, 1'b0);
                        exp_err.push_back(1'b1);
                        pos = st_header;
                    end else begin
                        w = word_width'($urandom);
                        sum = sum ^ w;
                        if (kept < room) begin
                            exp_data.push_back(w);
                            exp_last.push_back(idx == len - 1);
                            kept++;
                        end else begin
                            dropped = 1'b1;
                        end
                        serialize_word(w);
                        idx++;
                        if (idx == len) pos = st_trailer;
                    end
                end
                st_trailer: begin
                    w = bad_trailer ? sum ^ word_width'($urandom_range(1, 255)) : sum;
                    serialize_word(w);
                    exp_err.push_back(dropped || bad_trailer);
                    pos = st_header;
                end
                default: pos = st_header;
            endcase
        end
    endtask

    // zero bits decode as idle headers
    task automatic idle_until_empty();
        int waited;
        waited = 0;
        while ((exp_data.size() != 0 || exp_err.size() != 0) && waited < drain_limit) begin
            drive_bit(1'b0, 1'b0);
            waited++;
        end
    endtask

    always @(posedge bit_clk) begin
        if (reset == 1'b0) begin
            if (held) begin
                if (rx_valid !== 1'b1) begin
                    report_failure({test_name, ": rx_valid dropped before the word was taken"});
                end else begin
                    check_word({test_name, " hold"}, held_data, held_last, rx_data, rx_last);
                end
            end
            if (rx_valid && rx_ready) begin
                if (exp_data.size() == 0) begin
                    report_failure({test_name, ": a word arrived that the model did not expect"});
                end else begin
                    check_word(test_name, exp_data.pop_front(), exp_last.pop_front(),
                               rx_data, rx_last);
                end
            end
            held      = rx_valid && !rx_ready;
            held_data = rx_data;
            held_last = rx_last;
            if (frame_done) begin
                if (exp_err.size() == 0) begin
                    report_failure({test_name, ": a status arrived that the model did not expect"});
                end else begin
                    check_status(test_name, exp_err.pop_front(), frame_error);
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog timeout, the run did not finish in time");
    end

    initial begin
        int len;
        void'($urandom(60));
        serial_in  = 1'b0;
        frame_sync = 1'b0;
        rx_ready   = 1'b1;
        ready_mode = 0;
        held       = 1'b0;
        test_name  = "reset";
        // covers the reset window and four cycles after it
        repeat (8) begin
            @(negedge bit_clk);
            if (rx_valid !== 1'b0 || frame_done !== 1'b0) begin
                report_failure("rx_valid or frame_done high during or right after reset");
            end
        end
        test_name = "good";
        repeat (10) begin
            len = $urandom_range(1, 20);
            build_frame(op_data, len, 1'b0, -1, len);
        end
        idle_until_empty();
        test_name = "errors";
        repeat (2) begin
            len = $urandom_range(1, 10);
            build_frame(op_data, len, 1'b1, -1, len);
            build_frame(op_rsvd2, $urandom_range(0, 20), 1'b0, -1, 0);
            build_frame(op_rsvd3, $urandom_range(0, 20), 1'b0, -1, 0);
            build_frame(op_data, 0, 1'b0, -1, 0);
            build_frame(op_idle, $urandom_range(0, 20), 1'b0, -1, 0);
            len = $urandom_range(1, 10);
            build_frame(op_data, len, 1'b0, -1, len);
        end
        idle_until_empty();
        test_name = "backpressure";
        ready_mode = 1;
        repeat (10) begin
            idle_until_empty();
            len = $urandom_range(1, 15);
            build_frame(op_data, len, 1'b0, -1, len);
        end
        idle_until_empty();
        test_name = "overflow";
        ready_mode = 2;
        build_frame(op_data, 20, 1'b0, -1, fifo_depth);
        while (exp_err.size() != 0) drive_bit(1'b0, 1'b0);
        ready_mode = 0;
        idle_until_empty();
        test_name = "abort";
        repeat (3) begin
            len = $urandom_range(4, 16);
            build_frame(op_data, len, 1'b0, $urandom_range(0, len - 1), len);
            len = $urandom_range(1, 16);
            build_frame(op_data, len, 1'b0, -1, len);
        end
        idle_until_empty();
        repeat (40) drive_bit(1'b0, 1'b0);
        if (exp_data.size() != 0 || exp_err.size() != 0) begin
            report_failure("model queues are not empty at the end of the run");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* sources.f */
src/serial_rx_pkg.sv
src/bit_deserializer.sv
src/frame_parser.sv
src/word_fifo.sv
src/serial_rx_top.sv
verif/clock_gen.sv
verif/serial_rx_tb.sv

/* Makefile */
TOP = serial_rx_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f sources.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir
